//--- common/sdmacPkg.sv
//****************************************
// Shared types and register map of the SCSI DMA controller
// Slave addresses are longword addresses, byte offset bits 6:2
// Offsets from 0x40 up belong to the SCSI chip
//****************************************
`default_nettype none

package sdmacPkg;

    // CPU access to the controller, held until acknowledged
    typedef struct packed {
        logic        cs;
        logic        as;
        logic        rw;      // 1 = read
        logic [4:0]  addr;
        logic [31:0] wdata;
    } cpuSlaveReq_t;

    // One memory cycle driven while bus master
    typedef struct packed {
        logic        as;
        logic        rw;      // 1 = read memory
        logic [31:0] addr;
        logic [31:0] wdata;
    } masterCycle_t;

    typedef struct packed {
        logic intEna;         // Bit 2
        logic dmaDir;         // Bit 1, 1 = memory to SCSI
        logic rsvd;           // Stored and read back only
    } dmaCtrl_t;

    typedef struct packed {
        logic fifoEmpty;
        logic fifoFull;
        logic intPending;
        logic scsiInt;
        logic dmaBusy;
    } dmaStatus_t;

    // FIFO entry seen as a longword or as bytes, byte 0 is the MSB
    typedef union packed {
        logic [31:0]     lword;
        logic [0:3][7:0] bytes;
    } fifoWord_u;

    localparam logic [4:0] REG_WTC    = 5'h01;  // 0x04
    localparam logic [4:0] REG_CNTR   = 5'h02;  // 0x08
    localparam logic [4:0] REG_ACR    = 5'h03;  // 0x0C
    localparam logic [4:0] REG_ST_DMA = 5'h04;  // 0x10
    localparam logic [4:0] REG_ISTR   = 5'h07;  // 0x1C
    localparam logic [4:0] REG_WDADR  = 5'h10;  // 0x40
    localparam logic [4:0] REG_WDDATA = 5'h12;  // 0x48

endpackage

`default_nettype wire

//--- cpuSm/cpuBusMaster.sv
//****************************************
// Bus master moving one longword per memory cycle
// Holds the bus from grant to the last word
// Word count must be nonzero
//****************************************
`timescale 1ns/1ns
`default_nettype none

module cpuBusMaster
    import sdmacPkg::*;
(
    input  logic         SCLK,
    input  logic         nAS_,
    input  dmaCtrl_t     ctrl_i,
    input  logic         start_i,
    input  logic [31:0]  startAddr_i,
    input  logic [21:0]  wordCount_i,
    output logic         busReq_o,
    input  logic         busGrant_i,
    output masterCycle_t cycle_o,
    input  logic         memAck_i,
    input  logic [31:0]  memRdata_i,
    input  logic         fifoFull_i,
    input  logic         fifoEmpty_i,
    input  fifoWord_u    fifoWord_i,
    output logic         fifoPush_o,
    output fifoWord_u    fifoWord_o,
    output logic         fifoPop_o,
    output logic         done_o
);

    typedef enum logic [2:0] {S_IDLE, S_REQ, S_STROBE, S_WAIT, S_RELEASE} state_t;

    state_t      state;
    logic [21:0] wordsLeft;
    logic        cycleOk;

    // Memory to SCSI needs room, SCSI to memory needs a word
    assign cycleOk = ctrl_i.dmaDir ? !fifoFull_i : !fifoEmpty_i;

    assign fifoPush_o = (state == S_WAIT) & memAck_i & ctrl_i.dmaDir;
    assign fifoPop_o = (state == S_WAIT) & memAck_i & !ctrl_i.dmaDir;
    assign fifoWord_o = fifoWord_u'(memRdata_i);

    always_ff @(posedge SCLK or negedge nAS_) begin
        if (!nAS_) begin
            state <= S_IDLE;
            busReq_o <= 1'b0;
            cycle_o <= '0;
            wordsLeft <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        cycle_o.addr <= startAddr_i;
                        wordsLeft <= wordCount_i;
                        busReq_o <= 1'b1;
                        state <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (busGrant_i)
                        state <= S_STROBE;
                end
                S_STROBE: begin
                    if (cycleOk) begin
                        cycle_o.as <= 1'b1;
                        cycle_o.rw <= ctrl_i.dmaDir;
                        cycle_o.wdata <= fifoWord_i.lword;  // Head word, popped on ack
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (memAck_i) begin          // Slow memory stretches this state
                        cycle_o.as <= 1'b0;
                        cycle_o.addr <= cycle_o.addr + 32'd4;
                        wordsLeft <= wordsLeft - 22'd1;
                        state <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (wordsLeft == '0) begin
                        busReq_o <= 1'b0;
                        done_o <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        state <= S_STROBE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fifo/dmaFifo.sv
//****************************************
// Longword FIFO with byte packing on the SCSI side
// FIFO_DEPTH must be a power of 2
// Only one byte direction is used during a run
//****************************************
`timescale 1ns/1ns
`default_nettype none

module dmaFifo
    import sdmacPkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       SCLK,
    input  logic       nAS_,
    input  logic       start_i,
    input  logic       wordPush_i,
    input  fifoWord_u  wordIn_i,
    input  logic       wordPop_i,
    output fifoWord_u  wordOut_o,
    input  logic       bytePush_i,
    input  logic [7:0] byteIn_i,
    input  logic       bytePop_i,
    output logic [7:0] byteOut_o,
    input  logic       lastByte_i,
    output logic       empty_o,
    output logic       full_o
);

    localparam int PW = $clog2(FIFO_DEPTH);
    localparam int CW = PW + 1;

    fifoWord_u     mem [FIFO_DEPTH];
    logic [PW-1:0] wrPtr;
    logic [PW-1:0] rdPtr;
    logic [CW-1:0] count;
    logic [CW-1:0] countNext;
    logic [1:0]    byteOff;
    logic          byteEnd;
    logic          wrEn;
    logic          rdEn;
    fifoWord_u     packWord;
    fifoWord_u     packNext;

    assign byteEnd = (byteOff == 2'd3) | lastByte_i;
    assign wrEn = wordPush_i | (bytePush_i & byteEnd);
    assign rdEn = wordPop_i | (bytePop_i & byteEnd);
    assign countNext = count + CW'(wrEn) - CW'(rdEn);

    assign wordOut_o = mem[rdPtr];
    assign byteOut_o = wordOut_o.bytes[byteOff];

    // Unwritten bytes stay zero, which pads a short final word
    always_comb begin
        packNext = packWord;
        packNext.bytes[byteOff] = byteIn_i;
    end

    always_ff @(posedge SCLK) begin
        if (wrEn)
            mem[wrPtr] <= wordPush_i ? wordIn_i : packNext;
    end

    always_ff @(posedge SCLK or negedge nAS_) begin
        if (!nAS_) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            byteOff <= '0;
            packWord <= '0;
            empty_o <= 1'b1;
            full_o <= 1'b0;
        end else if (start_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            byteOff <= '0;
            packWord <= '0;
            empty_o <= 1'b1;
            full_o <= 1'b0;
        end else begin
            if (wrEn)
                wrPtr <= wrPtr + 1'b1;
            if (rdEn)
                rdPtr <= rdPtr + 1'b1;
            count <= countNext;
            empty_o <= (countNext == '0);
            full_o <= (countNext == CW'(FIFO_DEPTH));
            if (bytePush_i || bytePop_i)
                byteOff <= byteEnd ? 2'd0 : byteOff + 2'd1;
            if (bytePush_i)
                packWord <= byteEnd ? '0 : packNext;
        end
    end

endmodule

`default_nettype wire

//--- hdl/sdmacTop.sv
//****************************************
// SCSI DMA controller top level
// Bidirectional buses are split into in, out and enable
// Chip range 0x40 and up is served by the port sequencer
//****************************************
`timescale 1ns/1ns
`default_nettype none

module sdmacTop
    import sdmacPkg::*;
#(
    parameter int FIFO_DEPTH       = 8,
    parameter int IO_STROBE_CYCLES = 2
) (
    input  logic         SCLK,
    input  logic         nAS_,
    input  cpuSlaveReq_t slaveReq_i,
    output logic         dsack_o,
    output logic [31:0]  rdata_o,
    output logic         busReq_o,
    input  logic         busGrant_i,
    output masterCycle_t cycle_o,
    input  logic         memAck_i,
    input  logic [31:0]  memRdata_i,
    input  logic         nDreq_i,
    output logic         nDack_o,
    output logic         nIor_o,
    output logic         nIow_o,
    output logic         nCss_o,
    output logic         pdA0_o,
    output logic [7:0]   pdOut_o,
    input  logic [7:0]   pdIn_i,
    output logic         pdOe_o,
    input  logic         scsiInt_i,
    output logic         nInt_o
);

    logic        regAck, wdAck, wdSel;
    logic [31:0] regRdata, wdRdata;
    dmaCtrl_t    ctrl;
    logic        start, masterDone, portDone;
    logic [31:0] startAddr;
    logic [23:0] byteCount;
    logic [21:0] wordCount;
    logic        fifoEmpty, fifoFull, scsiIntSync;
    dmaStatus_t  status;
    fifoWord_u   wordToFifo, wordFromFifo;
    logic        wordPush, wordPop, bytePush, bytePop, lastByte;
    logic [7:0]  byteToFifo, byteFromFifo;

    // Read data and acknowledge by address range
    assign wdSel = (slaveReq_i.addr >= REG_WDADR);
    assign dsack_o = wdSel ? wdAck : regAck;
    assign rdata_o = wdSel ? wdRdata : regRdata;

    assign status = '{fifoEmpty: fifoEmpty, fifoFull: fifoFull, intPending: 1'b0,
                      scsiInt: scsiIntSync, dmaBusy: 1'b0};

    sdmacRegisters i_sdmacRegisters (
        .SCLK, .nAS_, .slaveReq_i, .status_i(status),
        .masterDone_i(masterDone), .portDone_i(portDone),
        .regAck_o(regAck), .regRdata_o(regRdata), .ctrl_o(ctrl), .start_o(start),
        .startAddr_o(startAddr), .byteCount_o(byteCount), .wordCount_o(wordCount), .nInt_o
    );

    cpuBusMaster i_cpuBusMaster (
        .SCLK, .nAS_, .ctrl_i(ctrl), .start_i(start), .startAddr_i(startAddr),
        .wordCount_i(wordCount), .busReq_o, .busGrant_i, .cycle_o, .memAck_i, .memRdata_i,
        .fifoFull_i(fifoFull), .fifoEmpty_i(fifoEmpty), .fifoWord_i(wordFromFifo),
        .fifoPush_o(wordPush), .fifoWord_o(wordToFifo), .fifoPop_o(wordPop),
        .done_o(masterDone)
    );

    dmaFifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_dmaFifo (
        .SCLK, .nAS_, .start_i(start),
        .wordPush_i(wordPush), .wordIn_i(wordToFifo), .wordPop_i(wordPop),
        .wordOut_o(wordFromFifo), .bytePush_i(bytePush), .byteIn_i(byteToFifo),
        .bytePop_i(bytePop), .byteOut_o(byteFromFifo), .lastByte_i(lastByte),
        .empty_o(fifoEmpty), .full_o(fifoFull)
    );

    scsiPort #(.IO_STROBE_CYCLES(IO_STROBE_CYCLES)) i_scsiPort (
        .SCLK, .nAS_, .slaveReq_i, .wdAck_o(wdAck), .wdRdata_o(wdRdata),
        .ctrl_i(ctrl), .start_i(start), .byteCount_i(byteCount),
        .fifoEmpty_i(fifoEmpty), .fifoFull_i(fifoFull),
        .bytePush_o(bytePush), .byteOut_o(byteToFifo), .bytePop_o(bytePop),
        .byteIn_i(byteFromFifo), .lastByte_o(lastByte),
        .nDreq_i, .nDack_o, .nIor_o, .nIow_o, .nCss_o, .pdA0_o,
        .pdOut_o, .pdIn_i, .pdOe_o, .scsiInt_i, .scsiInt_o(scsiIntSync),
        .done_o(portDone)
    );

endmodule

`default_nettype wire

//--- registers/sdmacRegisters.sv
//****************************************
// CPU register file, acked 2 cycles after cs and as are seen
// Byte count must be nonzero and below 2^24 - 3
// A read of ISTR clears intPending
//****************************************
`timescale 1ns/1ns
`default_nettype none

module sdmacRegisters
    import sdmacPkg::*;
(
    input  logic         SCLK,
    input  logic         nAS_,
    input  cpuSlaveReq_t slaveReq_i,
    input  dmaStatus_t   status_i,
    input  logic         masterDone_i,
    input  logic         portDone_i,
    output logic         regAck_o,
    output logic [31:0]  regRdata_o,
    output dmaCtrl_t     ctrl_o,
    output logic         start_o,
    output logic [31:0]  startAddr_o,
    output logic [23:0]  byteCount_o,
    output logic [21:0]  wordCount_o,
    output logic         nInt_o
);

    logic [1:0]  ackCnt;
    logic        regSel;
    logic        accept;
    logic        masterSeen;
    logic        portSeen;
    logic        dmaBusy;
    logic        intPending;
    logic [31:0] acr;
    logic [23:0] wtc;
    dmaStatus_t  status;
    logic [31:0] rdMux;

    assign regSel = slaveReq_i.cs & slaveReq_i.as & (slaveReq_i.addr < REG_WDADR);
    assign accept = regSel & (ackCnt == 2'd2);   // One edge per access
    assign regAck_o = regSel & (ackCnt == 2'd3);

    assign startAddr_o = acr;
    assign byteCount_o = wtc;
    assign wordCount_o = wtc[23:2] + 22'(|wtc[1:0]);  // Rounded up
    assign nInt_o = ~(ctrl_o.intEna & (intPending | status_i.scsiInt));

    always_comb begin
        status = status_i;
        status.intPending = intPending;
        status.dmaBusy = dmaBusy;
        case (slaveReq_i.addr)
            REG_CNTR: rdMux = 32'(ctrl_o);
            REG_ACR:  rdMux = acr;
            REG_WTC:  rdMux = 32'(wtc);
            REG_ISTR: rdMux = 32'(status);
            default:  rdMux = '0;
        endcase
    end

    always_ff @(posedge SCLK or negedge nAS_) begin
        if (!nAS_) begin
            ackCnt <= '0;
            ctrl_o <= '0;
            acr <= '0;
            wtc <= '0;
            start_o <= 1'b0;
            dmaBusy <= 1'b0;
            intPending <= 1'b0;
            masterSeen <= 1'b0;
            portSeen <= 1'b0;
        end else begin
            start_o <= 1'b0;
            if (!regSel)
                ackCnt <= '0;
            else if (ackCnt != 2'd3)
                ackCnt <= ackCnt + 2'd1;

            if (accept && !slaveReq_i.rw) begin
                case (slaveReq_i.addr)
                    REG_CNTR:   ctrl_o <= dmaCtrl_t'(slaveReq_i.wdata[2:0]);
                    REG_ACR:    acr <= {slaveReq_i.wdata[31:2], 2'b00};
                    REG_WTC:    wtc <= slaveReq_i.wdata[23:0];
                    REG_ST_DMA: start_o <= 1'b1;
                    default: ;
                endcase
            end
            if (accept && slaveReq_i.rw && slaveReq_i.addr == REG_ISTR)
                intPending <= 1'b0;

            // Run ends once both sides have reported done
            if (start_o) begin
                dmaBusy <= 1'b1;
                masterSeen <= 1'b0;
                portSeen <= 1'b0;
            end else if (dmaBusy) begin
                masterSeen <= masterSeen | masterDone_i;
                portSeen <= portSeen | portDone_i;
                if ((masterSeen | masterDone_i) && (portSeen | portDone_i)) begin
                    dmaBusy <= 1'b0;
                    intPending <= 1'b1;
                end
            end
        end
    end

    // Captured on the accept edge so ISTR shows intPending before the clear
    always_ff @(posedge SCLK) begin
        if (accept)
            regRdata_o <= rdMux;
    end

endmodule

`default_nettype wire

//--- scsiSm/scsiPort.sv
//****************************************
// Peripheral port sequencer for DREQ/DACK bytes and CPU cycles
// CPU cycles win when both are pending
// Only WDADR and WDDATA are acked in the chip range
//****************************************
`timescale 1ns/1ns
`default_nettype none

module scsiPort
    import sdmacPkg::*;
#(
    parameter int IO_STROBE_CYCLES = 2
) (
    input  logic         SCLK,
    input  logic         nAS_,
    input  cpuSlaveReq_t slaveReq_i,
    output logic         wdAck_o,
    output logic [31:0]  wdRdata_o,
    input  dmaCtrl_t     ctrl_i,
    input  logic         start_i,
    input  logic [23:0]  byteCount_i,
    input  logic         fifoEmpty_i,
    input  logic         fifoFull_i,
    output logic         bytePush_o,
    output logic [7:0]   byteOut_o,
    output logic         bytePop_o,
    input  logic [7:0]   byteIn_i,
    output logic         lastByte_o,
    input  logic         nDreq_i,
    output logic         nDack_o,
    output logic         nIor_o,
    output logic         nIow_o,
    output logic         nCss_o,
    output logic         pdA0_o,
    output logic [7:0]   pdOut_o,
    input  logic [7:0]   pdIn_i,
    output logic         pdOe_o,
    input  logic         scsiInt_i,
    output logic         scsiInt_o,
    output logic         done_o
);

    localparam int SW = $clog2(IO_STROBE_CYCLES) + 1;

    typedef enum logic [1:0] {S_IDLE, S_DMA, S_CPU, S_ACK} state_t;

    state_t        state;
    logic [SW-1:0] strobeCnt;
    logic [23:0]   bytesLeft;
    logic          active;
    logic          cpuReq;
    logic          dmaGo;
    logic          lastStrobe;
    logic [1:0]    intSync;

    assign cpuReq = slaveReq_i.cs & slaveReq_i.as &
                    ((slaveReq_i.addr == REG_WDADR) | (slaveReq_i.addr == REG_WDDATA));
    assign dmaGo = active & !nDreq_i & (ctrl_i.dmaDir ? !fifoEmpty_i : !fifoFull_i);
    assign lastStrobe = (strobeCnt == SW'(IO_STROBE_CYCLES - 1));

    // Byte moves on the last strobe cycle
    assign bytePush_o = (state == S_DMA) & lastStrobe & !ctrl_i.dmaDir;
    assign bytePop_o = (state == S_DMA) & lastStrobe & ctrl_i.dmaDir;
    assign byteOut_o = pdIn_i;
    assign lastByte_o = (bytesLeft == 24'd1);

    assign nDack_o = !(state == S_DMA);
    assign nCss_o = !(state == S_CPU);
    assign nIor_o = !(((state == S_DMA) & !ctrl_i.dmaDir) | ((state == S_CPU) & slaveReq_i.rw));
    assign nIow_o = !(((state == S_DMA) & ctrl_i.dmaDir) | ((state == S_CPU) & !slaveReq_i.rw));
    assign pdOe_o = !nIow_o;
    assign pdOut_o = (state == S_DMA) ? byteIn_i : slaveReq_i.wdata[7:0];
    assign pdA0_o = slaveReq_i.addr[1];    // WDADR vs WDDATA
    assign wdAck_o = (state == S_ACK);
    assign scsiInt_o = intSync[1];

    always_ff @(posedge SCLK or negedge nAS_) begin
        if (!nAS_) begin
            state <= S_IDLE;
            strobeCnt <= '0;
            bytesLeft <= '0;
            active <= 1'b0;
            done_o <= 1'b0;
            intSync <= '0;
        end else begin
            done_o <= 1'b0;
            intSync <= {intSync[0], scsiInt_i};
            if (start_i) begin
                bytesLeft <= byteCount_i;
                active <= 1'b1;
            end
            case (state)
                S_IDLE: begin                   // Strobes high at least this cycle
                    strobeCnt <= '0;
                    if (cpuReq)
                        state <= S_CPU;
                    else if (dmaGo)
                        state <= S_DMA;
                end
                S_DMA: begin
                    if (lastStrobe) begin
                        bytesLeft <= bytesLeft - 24'd1;
                        if (lastByte_o) begin
                            active <= 1'b0;
                            done_o <= 1'b1;
                        end
                        state <= S_IDLE;
                    end else begin
                        strobeCnt <= strobeCnt + 1'b1;
                    end
                end
                S_CPU: begin
                    if (lastStrobe)
                        state <= S_ACK;
                    else
                        strobeCnt <= strobeCnt + 1'b1;
                end
                S_ACK: begin
                    if (!slaveReq_i.as)
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge SCLK) begin
        if (state == S_CPU && lastStrobe)
            wdRdata_o <= {24'h0, pdIn_i};
    end

endmodule

`default_nettype wire

//--- verification/sdmacCases.txt
// dir addr count first, all hex, one transfer per line
// dir 1 = memory to SCSI, 0 = SCSI to memory; data byte i = first + i
0 00000100 00000010 00000011
1 00000200 00000010 00000040
0 00000302 0000000D 000000A0
1 00000040 0000000B 000000F8
0 00000080 00000001 00000007
1 000000C0 00000003 00000030
0 00000204 00000025 000000E0
1 00000380 00000021 00000055
0 00000000 00000004 000000FE
1 00000104 00000007 00000000

//--- verification/sdmacModels.sv
//****************************************
// Memory and SCSI device models for the testbench
// Memory covers byte addresses 0x000 to 0x3FF only
// Ack delays and DREQ gaps come from a fixed seed
// Device data reads as X when the bus is undriven or contended
//****************************************
`timescale 1ns/1ns
`default_nettype none

module memModel
    import sdmacPkg::*;
(
    input  logic         SCLK,
    input  logic         busReq_i,
    output logic         busGrant_o,
    input  masterCycle_t cycle_i,
    output logic         memAck_o,
    output logic [31:0]  memRdata_o
);

    logic [31:0] mem [0:255];     // Longwords, index is address bits 9:2
    integer      seed;
    int          delay;
    logic        waiting;

    initial begin
        seed = 32'hfc83_21ea;
        busGrant_o = 1'b0;
        memAck_o = 1'b0;
        memRdata_o = '0;
        waiting = 1'b0;
        delay = 0;
        for (int i = 0; i < 256; i++)
            mem[i] = 32'hA5A5_0000 | i;
    end

    always @(negedge SCLK) begin
        busGrant_o <= busReq_i;
        if (!cycle_i.as) begin
            memAck_o <= 1'b0;
            waiting = 1'b0;
        end else if (!memAck_o) begin
            if (!waiting) begin
                delay = $unsigned($random(seed)) % 4;   // 0 to 3 cycles
                waiting = 1'b1;
            end
            if (delay == 0) begin
                memAck_o <= 1'b1;
                if (cycle_i.rw)
                    memRdata_o <= mem[cycle_i.addr[9:2]];
                else
                    mem[cycle_i.addr[9:2]] = cycle_i.wdata;
            end else begin
                delay = delay - 1;
            end
        end
    end

endmodule

module scsiDevModel (
    input  logic       SCLK,
    input  logic       dreqEna_i,
    output logic       nDreq_o,
    input  logic       nDack_i,
    input  logic       nIor_i,
    input  logic       nIow_i,
    input  logic       nCss_i,
    input  logic       a0_i,
    input  logic [7:0] data_i,
    input  logic       oe_i,
    output logic [7:0] data_o
);

    logic [7:0] txData [0:1023];   // Bytes sent toward memory
    logic [7:0] rxData [0:1023];   // Bytes received from memory
    logic [7:0] regs [0:1];        // A0 = 0 is the address register
    int         txIdx;
    int         rxIdx;
    int         regWrites;
    integer     seed;
    logic       dackPrev;
    logic       cssPrev;

    initial begin
        seed = 32'hfc83_21ea;
        nDreq_o = 1'b1;
        data_o = '0;
        txIdx = 0;
        rxIdx = 0;
        regWrites = 0;
        dackPrev = 1'b1;
        cssPrev = 1'b1;
        regs[0] = '0;
        regs[1] = '0;
    end

    always @(negedge SCLK) begin
        dackPrev <= nDack_i;
        cssPrev <= nCss_i;
        nDreq_o <= !(dreqEna_i && ($unsigned($random(seed)) % 4 != 0));  // Random gaps

        // One byte per falling edge of DACK
        if (!nDack_i && dackPrev) begin
            if (!nIor_i) begin
                data_o <= oe_i ? 8'hxx : txData[txIdx];   // Both sides driving
                txIdx = txIdx + 1;
            end else if (!nIow_i) begin
                rxData[rxIdx] = oe_i ? data_i : 8'hxx;
                rxIdx = rxIdx + 1;
            end
        end

        if (!nCss_i && cssPrev) begin
            if (!nIor_i) begin
                data_o <= oe_i ? 8'hxx : regs[a0_i];
            end else if (!nIow_i) begin
                regs[a0_i] = oe_i ? data_i : 8'hxx;     // Nothing on the bus
                regWrites = regWrites + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/sdmacTb.sv
//****************************************
// Testbench for the SCSI DMA controller
// Cases come from verification/sdmacCases.txt
// Stops at the first mismatch
//****************************************
`timescale 1ns/1ns
`default_nettype none

module sdmacTb
    import sdmacPkg::*;
();

    localparam int MAX_CASES = 16;

    logic         SCLK;
    logic         nAS_;
    cpuSlaveReq_t slaveReq;
    logic         dsack;
    logic [31:0]  rdata;
    logic         busReq;
    logic         busGrant;
    masterCycle_t cycle;
    logic         memAck;
    logic [31:0]  memRdata;
    logic         nDreq;
    logic         nDack;
    logic         nIor;
    logic         nIow;
    logic         nCss;
    logic         pdA0;
    logic [7:0]   pdOut;
    logic [7:0]   pdIn;
    logic         pdOe;
    logic         scsiInt;
    logic         nInt;
    logic         dreqEna;
    logic [31:0]  caseData [0:4*MAX_CASES-1];   // dir, addr, count, first byte
    int           numCases;
    int           totalBytes;
    int           cycleCount;
    int           cycleLimit;

    sdmacTop #(.FIFO_DEPTH(8), .IO_STROBE_CYCLES(2)) i_sdmacTop (
        .SCLK(SCLK), .nAS_(nAS_), .slaveReq_i(slaveReq), .dsack_o(dsack), .rdata_o(rdata),
        .busReq_o(busReq), .busGrant_i(busGrant), .cycle_o(cycle), .memAck_i(memAck),
        .memRdata_i(memRdata), .nDreq_i(nDreq), .nDack_o(nDack), .nIor_o(nIor),
        .nIow_o(nIow), .nCss_o(nCss), .pdA0_o(pdA0), .pdOut_o(pdOut), .pdIn_i(pdIn),
        .pdOe_o(pdOe), .scsiInt_i(scsiInt), .nInt_o(nInt)
    );

    memModel i_memModel (
        .SCLK(SCLK), .busReq_i(busReq), .busGrant_o(busGrant), .cycle_i(cycle),
        .memAck_o(memAck), .memRdata_o(memRdata)
    );

    scsiDevModel i_scsiDevModel (
        .SCLK(SCLK), .dreqEna_i(dreqEna), .nDreq_o(nDreq), .nDack_i(nDack), .nIor_i(nIor),
        .nIow_i(nIow), .nCss_i(nCss), .a0_i(pdA0), .data_i(pdOut), .oe_i(pdOe),
        .data_o(pdIn)
    );

    always #10 SCLK = ~SCLK;

    always @(posedge SCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the DUT did not finish", cycleCount);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic expectEqual(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic cpuAccess(input logic rw, input logic [4:0] addr,
                             input logic [31:0] wdata, output logic [31:0] data);
        slaveReq.cs = 1'b1;
        slaveReq.as = 1'b1;
        slaveReq.rw = rw;
        slaveReq.addr = addr;
        slaveReq.wdata = wdata;
        @(negedge SCLK);
        while (!dsack)
            @(negedge SCLK);
        data = rdata;
        slaveReq = '0;
        @(negedge SCLK);
        while (dsack)
            @(negedge SCLK);
    endtask

    task automatic busWrite(input logic [4:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        cpuAccess(1'b0, addr, wdata, unused);
    endtask

    task automatic busRead(input logic [4:0] addr, output logic [31:0] data);
        cpuAccess(1'b1, addr, '0, data);
    endtask

    // Big-endian packing, bytes past the count are zero
    function automatic logic [31:0] expectedWord(input logic [7:0] first, input int i,
                                                 input int count);
        logic [31:0] w;
        w = '0;
        for (int j = 0; j < 4; j++)
            if (4 * i + j < count)
                w[31 - 8 * j -: 8] = first + 8'(4 * i + j);
        return w;
    endfunction

    task automatic checkRegisters();
        logic [31:0] got;
        dmaStatus_t  st;
        busRead(REG_ISTR, got);
        st = got[4:0];
        expectEqual("reset fifoEmpty", st.fifoEmpty, 1'b1);
        expectEqual("reset intPending", st.intPending, 1'b0);
        expectEqual("reset dmaBusy", st.dmaBusy, 1'b0);
        expectEqual("reset nInt", nInt, 1'b1);
        busWrite(REG_CNTR, 32'h5);
        busRead(REG_CNTR, got);
        expectEqual("CNTR readback", got, 32'h5);
        busWrite(REG_ACR, 32'h1234_5677);
        busRead(REG_ACR, got);
        expectEqual("ACR readback", got, 32'h1234_5674);   // Low bits dropped
        busWrite(REG_WTC, 32'hAB12_3456);
        busRead(REG_WTC, got);
        expectEqual("WTC readback", got, 32'h0012_3456);
    endtask

    task automatic runCase(input int n);
        logic        dir;
        logic [31:0] addr;
        int          count;
        int          words;
        logic [7:0]  first;
        logic [31:0] got;
        dmaStatus_t  st;
        dmaCtrl_t    ctrl;
        dir = caseData[4*n][0];
        addr = {caseData[4*n+1][31:2], 2'b00};
        count = caseData[4*n+2];
        first = caseData[4*n+3][7:0];
        words = (count + 3) / 4;
        if (dir) begin
            for (int i = 0; i < words; i++)
                i_memModel.mem[addr[9:2] + i] = expectedWord(first, i, count);
            i_scsiDevModel.rxIdx = 0;
        end else begin
            for (int k = 0; k < count; k++)
                i_scsiDevModel.txData[k] = first + 8'(k);
            i_scsiDevModel.txIdx = 0;
        end

        ctrl = '0;
        ctrl.intEna = 1'b1;
        ctrl.dmaDir = dir;
        busWrite(REG_CNTR, {29'h0, ctrl});
        busWrite(REG_ACR, caseData[4*n+1]);
        busWrite(REG_WTC, 32'(count));
        dreqEna = 1'b1;
        busWrite(REG_ST_DMA, 32'h0);
        while (nInt)
            @(negedge SCLK);
        dreqEna = 1'b0;
        expectEqual($sformatf("case %0d busReq after run", n), busReq, 1'b0);

        busRead(REG_ISTR, got);
        st = got[4:0];
        expectEqual($sformatf("case %0d intPending", n), st.intPending, 1'b1);
        expectEqual($sformatf("case %0d dmaBusy", n), st.dmaBusy, 1'b0);
        expectEqual($sformatf("case %0d fifoEmpty", n), st.fifoEmpty, 1'b1);
        expectEqual($sformatf("case %0d nInt after ISTR read", n), nInt, 1'b1);

        if (dir) begin
            expectEqual($sformatf("case %0d bytes received", n), i_scsiDevModel.rxIdx, count);
            for (int k = 0; k < count; k++)
                expectEqual($sformatf("case %0d byte %0d", n, k),
                            i_scsiDevModel.rxData[k], 8'(first + k));
        end else begin
            expectEqual($sformatf("case %0d bytes sent", n), i_scsiDevModel.txIdx, count);
            for (int i = 0; i < words; i++)
                expectEqual($sformatf("case %0d word at 0x%03h", n, addr + 4 * i),
                            i_memModel.mem[addr[9:2] + i], expectedWord(first, i, count));
        end
    endtask

    task automatic checkChipAccess();
        logic [31:0] got;
        int          writesBefore;
        dmaStatus_t  st;
        writesBefore = i_scsiDevModel.regWrites;
        busWrite(REG_WDADR, 32'h17);
        busWrite(REG_WDDATA, 32'h5C);
        expectEqual("chip writes seen", i_scsiDevModel.regWrites, writesBefore + 2);
        expectEqual("chip address register", i_scsiDevModel.regs[0], 8'h17);   // A0 low
        expectEqual("chip data register", i_scsiDevModel.regs[1], 8'h5C);
        i_scsiDevModel.regs[1] = 8'hC3;
        busRead(REG_WDDATA, got);
        expectEqual("WDDATA read", got, 32'hC3);
        busRead(REG_WDADR, got);
        expectEqual("WDADR read", got, 32'h17);

        // intEna is still set from the last case
        scsiInt = 1'b1;
        while (nInt)
            @(negedge SCLK);
        busRead(REG_ISTR, got);
        st = got[4:0];
        expectEqual("ISTR scsiInt", st.scsiInt, 1'b1);
        expectEqual("ISTR intPending with chip interrupt", st.intPending, 1'b0);
        expectEqual("nInt held by chip interrupt", nInt, 1'b0);
        scsiInt = 1'b0;
        while (!nInt)
            @(negedge SCLK);
    endtask

    initial begin
        SCLK = 1'b0;
        nAS_ = 1'b0;
        slaveReq = '0;
        dreqEna = 1'b0;
        scsiInt = 1'b0;
        cycleCount = 0;
        for (int i = 0; i < 4 * MAX_CASES; i++)
            caseData[i] = '1;                   // All ones marks the end
        $readmemh("verification/sdmacCases.txt", caseData);
        numCases = 0;
        totalBytes = 0;
        while (numCases < MAX_CASES && caseData[4*numCases] !== '1) begin
            totalBytes = totalBytes + caseData[4*numCases+2];
            numCases = numCases + 1;
        end
        cycleLimit = 1000 + 40 * totalBytes;
        assert (numCases > 0) else begin
            $display("No transfer cases were read from verification/sdmacCases.txt");
            $display("** FAIL **");
            $fatal(1);
        end

        repeat (5) @(negedge SCLK);
        nAS_ = 1'b1;
        @(negedge SCLK);
        checkRegisters();
        for (int n = 0; n < numCases; n++)
            runCase(n);
        checkChipAccess();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/sdmacPkg.sv
registers/sdmacRegisters.sv
cpuSm/cpuBusMaster.sv
fifo/dmaFifo.sv
scsiSm/scsiPort.sv
hdl/sdmacTop.sv
verification/sdmacModels.sv
verification/sdmacTb.sv
